//--- verilog/zx_mem_defs.svh
`ifndef ZX_MEM_DEFS_SVH
`define ZX_MEM_DEFS_SVH

// ============================================================
// SDRAM layout
// ============================================================

// Byte address width of the SDRAM
`define ZX_SDRAM_AW 25

// Boot ROM image as written by the download path
`define ZX_ROM_BASE 25'h150000

// Upper address bits of the 256K area holding all ROM pages
`define ZX_ROM_AREA 3'b101

// ============================================================
// I/O port decode
// ============================================================

// Pentagon 1024 extension port EFF7, decoded on A15..A12 and A3
`define ZX_PORT_EFF7_MASK 16'hF008
`define ZX_PORT_EFF7_VAL  16'hE000

// Turbo divider mask, one bit per halving of the CPU clock
`define ZX_TURBO_W 5

`endif

//--- verilog/zx_mem_pkg.sv
`include "zx_mem_defs.svh"

package zx_mem_pkg;

	// Memory model, as selected from the menu
	typedef enum logic [2:0] {
		MEM_128K  = 3'd0,
		MEM_P1024 = 3'd1,
		MEM_PROFI = 3'd2,  // Runs as plain 128K here
		MEM_48K   = 3'd3,
		MEM_PLUS3 = 3'd4
	} memory_mode_e;

	// One CPU bus cycle, strobes active high
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  dout;
		logic        mreq;
		logic        iorq;
		logic        rd;
		logic        wr;
		logic        m1;
	} cpu_bus_t;

	// Boot ROM download stream
	typedef struct packed {
		logic                    active;
		logic                    wr;
		logic [`ZX_SDRAM_AW-1:0] addr;
		logic [7:0]              data;
	} dload_t;

	typedef struct packed {
		logic [5:0] ram_page;      // Bank seen at C000
		logic [3:0] rom_page;
		logic       special;       // +3 all-RAM layout on
		logic [1:0] special_cfg;
		logic       write_rom_ok;  // 0000-3FFF is writable
	} page_state_t;

	// One access after address mapping
	typedef struct packed {
		logic [`ZX_SDRAM_AW-1:0] addr;
		logic [7:0]              din;
		logic                    rd;
		logic                    we;
	} mem_access_t;

	typedef struct packed {
		logic                    req;   // Toggles once per request
		logic [`ZX_SDRAM_AW-2:0] addr;  // 16-bit word address
		logic [1:0]              ds;
		logic [15:0]             data;
		logic                    we;
	} sdram_req_t;

endpackage

//--- verilog/zx_cpu_clock.sv
`timescale 1ns/1ps
`include "zx_mem_defs.svh"

module zx_cpu_clock (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic [2:0] speed_sel,
	input  logic       pause,
	input  logic       ram_ready,
	output logic       ce_cpu_p,
	output logic       ce_cpu_n
);

	localparam int TW = `ZX_TURBO_W;

	logic [TW:0]   counter;
	logic [TW-1:0] turbo;      // Mask in use
	logic [TW-1:0] turbo_req;  // Mask asked for by speed_sel
	logic [TW-1:0] phase_n;
	logic          ce_tp;
	logic          ce_tn;
	logic          cpu_en;
	logic [1:0]    settle;

	// 3.5, 7, 14, 28 and 56 MHz
	assign turbo_req = {TW{1'b1}} >> speed_sel;

	// Counter value that marks the middle of a CPU period
	assign phase_n = turbo ^ (turbo >> 1);

	// ============================================================
	// Phase generation
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			counter <= '0;
			ce_tp   <= 1'b0;
			ce_tn   <= 1'b0;
		end else begin
			counter <= counter + 1'd1;
			ce_tp   <= ~|(counter & {1'b0, turbo});
			ce_tn   <= ~|((counter & {1'b0, turbo}) ^ {1'b0, phase_n});
		end
	end

	// ============================================================
	// CPU enable
	// ============================================================

	// Updated only on the negative phase so no half cycle gets cut
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cpu_en <= 1'b0;
			settle <= 2'd0;
			turbo  <= turbo_req;
		end else if (ce_tn) begin
			if (settle != 2'd0)
				settle <= settle + 1'd1;

			if (turbo != turbo_req) begin
				// New speed, hold the CPU while the divider settles
				cpu_en <= 1'b0;
				settle <= 2'd1;
				turbo  <= turbo_req;
			end else if (!cpu_en && settle == 2'd0 && ram_ready) begin
				cpu_en <= ~pause;
			end else if (turbo[TW-1:TW-2] == 2'b00 && !ram_ready) begin
				cpu_en <= 1'b0;  // SDRAM too slow at 14 MHz and up
			end else if (cpu_en && pause) begin
				cpu_en <= 1'b0;
			end
		end
	end

	assign ce_cpu_p = cpu_en & ce_tp;
	assign ce_cpu_n = cpu_en & ce_tn;

endmodule

//--- verilog/zx_paging.sv
`timescale 1ns/1ps
`include "zx_mem_defs.svh"

module zx_paging (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  zx_mem_pkg::cpu_bus_t    cpu,
	input  zx_mem_pkg::memory_mode_e mem_mode,
	output zx_mem_pkg::page_state_t page
);

	zx_mem_pkg::memory_mode_e mode;  // Model in force since last reset

	logic       io_wr;
	logic       io_wr_q;
	logic       wr_edge;
	logic       zx48;
	logic       p1024;
	logic       plus3;

	// Port 7FFD
	logic [2:0] bank_7ffd;
	logic       rom_7ffd;
	logic       lock_7ffd;

	logic [2:0] reg_1ffd;   // Special, then the two config bits
	logic       eff7_128;   // EFF7 bit 2 forces plain 128K paging
	logic [2:0] page_hi;    // Pentagon page bits above bank

	logic       page_disable;
	logic       sel_7ffd;
	logic       sel_1ffd;
	logic       sel_eff7;

	always_comb begin
		zx48  = 1'b0;
		p1024 = 1'b0;
		plus3 = 1'b0;
		case (mode)
			zx_mem_pkg::MEM_48K:   zx48  = 1'b1;
			zx_mem_pkg::MEM_P1024: p1024 = 1'b1;
			zx_mem_pkg::MEM_PLUS3: plus3 = 1'b1;
			zx_mem_pkg::MEM_PROFI,
			zx_mem_pkg::MEM_128K:  ;
			default:               ;
		endcase
	end

	// ============================================================
	// Port decode
	// ============================================================

	assign io_wr   = cpu.iorq & cpu.wr & ~cpu.m1;
	assign wr_edge = io_wr & ~io_wr_q;

	// On Pentagon 1024 bit 5 is a page bit unless EFF7 says otherwise
	assign page_disable = zx48 | (~p1024 & lock_7ffd) | (p1024 & eff7_128 & lock_7ffd);

	assign sel_7ffd = ~cpu.addr[15] & ~cpu.addr[1] & (cpu.addr[14] | ~plus3) & ~page_disable;
	assign sel_1ffd = ~cpu.addr[1] & cpu.addr[12] & (cpu.addr[15:13] == 3'b000)
		& plus3 & ~page_disable;
	assign sel_eff7 = (cpu.addr & `ZX_PORT_EFF7_MASK) == `ZX_PORT_EFF7_VAL;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mode      <= mem_mode;
			io_wr_q   <= 1'b0;
			bank_7ffd <= 3'd0;
			rom_7ffd  <= 1'b0;
			lock_7ffd <= 1'b0;
			reg_1ffd  <= 3'd0;
			eff7_128  <= 1'b0;
			page_hi   <= 3'd0;
		end else begin
			io_wr_q <= io_wr;
			if (wr_edge) begin
				if (sel_7ffd) begin
					bank_7ffd <= cpu.dout[2:0];
					rom_7ffd  <= cpu.dout[4];
					lock_7ffd <= cpu.dout[5];
					if (p1024 && !eff7_128)
						page_hi <= {cpu.dout[5], cpu.dout[7:6]};
				end else if (sel_1ffd) begin
					reg_1ffd <= cpu.dout[2:0];
				end
				if (p1024 && sel_eff7)
					eff7_128 <= cpu.dout[2];
			end
		end
	end

	// ============================================================
	// Page outputs
	// ============================================================

	always_comb begin
		if (plus3)
			page.rom_page = {2'b10, reg_1ffd[2], rom_7ffd};
		else
			page.rom_page = {zx48, 2'b11, zx48 | rom_7ffd};

		page.ram_page     = {page_hi, bank_7ffd};
		page.special      = reg_1ffd[0];
		page.special_cfg  = reg_1ffd[2:1];
		page.write_rom_ok = reg_1ffd[0];  // All-RAM layouts only
	end

endmodule

//--- verilog/zx_addr_map.sv
`timescale 1ns/1ps
`include "zx_mem_defs.svh"

module zx_addr_map (
	input  zx_mem_pkg::cpu_bus_t    cpu,
	input  zx_mem_pkg::dload_t      dload,
	input  zx_mem_pkg::page_state_t page,
	output zx_mem_pkg::mem_access_t acc
);

	localparam int AW = `ZX_SDRAM_AW;

	logic [13:0] offs;
	logic [2:0]  sp_bank;  // Bank in the +3 all-RAM layout
	logic [1:0]  cfg;

	// 16K RAM bank in the bottom of SDRAM
	function automatic logic [AW-1:0] ram_at(input logic [5:0] bank, input logic [13:0] a);
		ram_at = {{(AW-20){1'b0}}, bank, a};
	endfunction

	function automatic logic [AW-1:0] rom_at(input logic [3:0] rom, input logic [13:0] a);
		rom_at = {{(AW-21){1'b0}}, `ZX_ROM_AREA, rom, a};
	endfunction

	assign offs = cpu.addr[13:0];
	assign cfg  = page.special_cfg;

	// ============================================================
	// +3 special layouts
	// ============================================================

	// 0,1,2,3 / 4,5,6,7 / 4,5,6,3 / 4,7,6,3
	always_comb begin
		case (cpu.addr[15:14])
			2'b00:   sp_bank = {|cfg, 2'b00};
			2'b01:   sp_bank = {|cfg, &cfg, 1'b1};
			2'b10:   sp_bank = {|cfg, 2'b10};
			default: sp_bank = {~cfg[1] & cfg[0], 2'b11};
		endcase
	end

	// ============================================================
	// Access select
	// ============================================================

	always_comb begin
		if (dload.active) begin
			// Download owns the bus, CPU strobes are ignored
			acc.addr = `ZX_ROM_BASE + dload.addr;
			acc.din  = dload.data;
			acc.rd   = 1'b0;
			acc.we   = dload.wr;
		end else begin
			if (page.special) begin
				acc.addr = ram_at({3'd0, sp_bank}, offs);
			end else begin
				case (cpu.addr[15:14])
					2'b00:   acc.addr = rom_at(page.rom_page, offs);
					2'b01:   acc.addr = ram_at(6'd5, offs);
					2'b10:   acc.addr = ram_at(6'd2, offs);
					default: acc.addr = ram_at(page.ram_page, offs);
				endcase
			end
			acc.din = cpu.dout;
			acc.rd  = cpu.mreq & cpu.rd;
			acc.we  = (page.write_rom_ok | cpu.addr[15] | cpu.addr[14]) & cpu.mreq & cpu.wr;
		end
	end

endmodule

//--- verilog/zx_sdram_port.sv
`timescale 1ns/1ps
`include "zx_mem_defs.svh"

module zx_sdram_port (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  zx_mem_pkg::mem_access_t acc,
	input  logic                    sdram_ack,
	input  logic [15:0]             sdram_q,
	output zx_mem_pkg::sdram_req_t  sdram_out,
	output logic                    ram_ready,
	output logic [7:0]              mem_rdata
);

	logic                    rd_q1;
	logic                    rd_q2;    // Second delay lets paging settle
	logic                    we_q;
	logic                    new_req;
	logic                    issue;
	logic                    req;
	logic [`ZX_SDRAM_AW-1:0] addr_q;
	logic [7:0]              din_q;
	logic                    we_lat;

	assign new_req = (rd_q1 & ~rd_q2) | (acc.we & ~we_q);
	assign issue   = new_req & (req == sdram_ack);  // Nothing while one is in flight

	// ============================================================
	// Request toggle
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_q1 <= 1'b0;
			rd_q2 <= 1'b0;
			we_q  <= 1'b0;
			req   <= sdram_ack;
		end else begin
			rd_q1 <= acc.rd;
			rd_q2 <= rd_q1;
			we_q  <= acc.we;
			if (issue)
				req <= ~req;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (issue) begin
			addr_q <= acc.addr;
			din_q  <= acc.din;
			we_lat <= acc.we;
		end
	end

	always_comb begin
		sdram_out.req  = req;
		sdram_out.addr = addr_q[`ZX_SDRAM_AW-1:1];
		sdram_out.ds   = we_lat ? {addr_q[0], ~addr_q[0]} : 2'b11;  // Reads fetch the word
		sdram_out.data = {din_q, din_q};
		sdram_out.we   = we_lat;
	end

	assign ram_ready = (sdram_ack == req) & ~new_req;
	assign mem_rdata = addr_q[0] ? sdram_q[15:8] : sdram_q[7:0];

endmodule

//--- verilog/zx_memory.sv
`timescale 1ns/1ps

module zx_memory (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  zx_mem_pkg::cpu_bus_t     cpu,
	input  zx_mem_pkg::dload_t       dload,
	input  zx_mem_pkg::memory_mode_e mem_mode,
	input  logic [2:0]               speed_sel,
	input  logic                     pause,
	input  logic                     sdram_ack,
	input  logic [15:0]              sdram_q,
	output zx_mem_pkg::sdram_req_t   sdram_out,
	output logic [7:0]               mem_rdata,
	output logic                     ce_cpu_p,
	output logic                     ce_cpu_n
);

	zx_mem_pkg::page_state_t page;
	zx_mem_pkg::mem_access_t acc;
	logic                    ram_ready;

	// ============================================================
	// CPU timing
	// ============================================================

	zx_cpu_clock u_cpu_clock (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.speed_sel (speed_sel),
		.pause     (pause),
		.ram_ready (ram_ready),
		.ce_cpu_p  (ce_cpu_p),
		.ce_cpu_n  (ce_cpu_n)
	);

	// ============================================================
	// Memory path
	// ============================================================

	zx_paging u_paging (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.cpu      (cpu),
		.mem_mode (mem_mode),
		.page     (page)
	);

	zx_addr_map u_addr_map (
		.cpu   (cpu),
		.dload (dload),
		.page  (page),
		.acc   (acc)
	);

	// Single SDRAM client
	zx_sdram_port u_sdram_port (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.acc       (acc),
		.sdram_ack (sdram_ack),
		.sdram_q   (sdram_q),
		.sdram_out (sdram_out),
		.ram_ready (ram_ready),
		.mem_rdata (mem_rdata)
	);

endmodule

//--- verif/zx_sdram_model.sv
`timescale 1ns/1ps

module zx_sdram_model (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  zx_mem_pkg::sdram_req_t sdram_out,
	output logic                   sdram_ack,
	output logic [15:0]            sdram_q
);

	logic [15:0] mem [int];  // Word array, filled on first write
	int          delay;
	logic        busy;

	always @(posedge clk_sys) begin
		if (reset) begin
			sdram_ack <= 1'b0;
			sdram_q   <= 16'h0000;
			busy      <= 1'b0;
			delay     <= 0;
		end else if (!busy && sdram_out.req != sdram_ack) begin
			busy  <= 1'b1;
			delay <= $urandom_range(1, 5);
		end else if (busy && delay > 1) begin
			delay <= delay - 1;
		end else if (busy) begin
			if (sdram_out.we) begin
				if (!mem.exists(int'(sdram_out.addr)))
					mem[int'(sdram_out.addr)] = 16'h0000;
				if (sdram_out.ds[0])
					mem[int'(sdram_out.addr)][7:0] = sdram_out.data[7:0];
				if (sdram_out.ds[1])
					mem[int'(sdram_out.addr)][15:8] = sdram_out.data[15:8];
			end else if (mem.exists(int'(sdram_out.addr))) begin
				sdram_q <= mem[int'(sdram_out.addr)];
			end else begin
				// Unwritten words read back a pattern of the whole address
				sdram_q <= sdram_out.addr[15:0] ^ {sdram_out.addr[23:16], 8'h5A};
			end
			sdram_ack <= sdram_out.req;
			busy      <= 1'b0;
		end
	end

endmodule

//--- verif/zx_memory_tb.sv
`timescale 1ns/1ps
`include "zx_mem_defs.svh"

module zx_memory_tb;

	localparam int CYCLE_LIMIT = 1800 + 6 * 450 + 1000;  // Speed test, memory tests, margin

	typedef struct packed {
		logic [24:0] addr;
		logic        we;
		logic [7:0]  data;
	} exp_req_t;

	logic                     clk_sys;
	logic                     reset;
	zx_mem_pkg::cpu_bus_t     cpu;
	zx_mem_pkg::dload_t       dload;
	zx_mem_pkg::memory_mode_e mem_mode;
	logic [2:0]               speed_sel;
	logic                     pause;
	logic                     sdram_ack;
	logic [15:0]              sdram_q;
	zx_mem_pkg::sdram_req_t   sdram_out;
	logic [7:0]               mem_rdata;
	logic                     ce_cpu_p;
	logic                     ce_cpu_n;

	exp_req_t   exp_q[$];
	logic [7:0] shadow_mem [int];
	logic       prev_req;
	logic       pause_watch;
	int         errors;
	int         failed_tests;
	int         test_count;
	int         test_err0;
	int         cycles;
	int         seed_val;

	// Shadow paging state
	zx_mem_pkg::memory_mode_e s_mode;
	logic [2:0] s_bank;
	logic       s_rom;
	logic       s_lock;
	logic [2:0] s_1ffd;
	logic       s_eff7;
	logic [2:0] s_hi;

	zx_memory uut (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cpu       (cpu),
		.dload     (dload),
		.mem_mode  (mem_mode),
		.speed_sel (speed_sel),
		.pause     (pause),
		.sdram_ack (sdram_ack),
		.sdram_q   (sdram_q),
		.sdram_out (sdram_out),
		.mem_rdata (mem_rdata),
		.ce_cpu_p  (ce_cpu_p),
		.ce_cpu_n  (ce_cpu_n)
	);

	zx_sdram_model u_sdram (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.sdram_out (sdram_out),
		.sdram_ack (sdram_ack),
		.sdram_q   (sdram_q)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// ============================================================
	// Checks on each request toggle
	// ============================================================

	always @(posedge clk_sys) begin
		exp_req_t e;
		if (reset) begin
			prev_req <= sdram_out.req;
		end else if (sdram_out.req != prev_req) begin
			prev_req <= sdram_out.req;
			assert (exp_q.size() != 0) else begin
				$display("Unexpected SDRAM request at %0d ns, addr %h", $time, sdram_out.addr);
				errors++;
			end
			if (exp_q.size() != 0) begin
				e = exp_q.pop_front();
				assert (sdram_out.addr == e.addr[24:1] && sdram_out.we == e.we) else begin
					$display("[ERROR] %0d ns: request addr %h we %b, expected %h we %b",
						$time, {sdram_out.addr, 1'b0}, sdram_out.we, e.addr, e.we);
					errors++;
				end
				if (e.we) begin
					assert (sdram_out.ds == {e.addr[0], ~e.addr[0]}
						&& sdram_out.data == {e.data, e.data}) else begin
						$display("[ERROR] %0d ns: write ds %b data %h, expected byte %h",
							$time, sdram_out.ds, sdram_out.data, e.data);
						errors++;
					end
				end
			end
		end
	end

	always @(negedge clk_sys) begin
		if (pause_watch) begin
			assert (!ce_cpu_p && !ce_cpu_n) else begin
				$display("[ERROR] %0d ns: CPU enable pulse while paused", $time);
				errors++;
			end
		end
	end

	// ============================================================
	// Shadow memory map
	// ============================================================

	function automatic logic [24:0] exp_addr(input logic [15:0] a);
		logic [2:0] sp;
		logic [3:0] rom;
		if (s_mode == zx_mem_pkg::MEM_PLUS3 && s_1ffd[0]) begin
			case ({s_1ffd[2:1], a[15:14]})
				4'b00_00, 4'b00_01, 4'b00_10, 4'b00_11: sp = {1'b0, a[15:14]};
				4'b01_00, 4'b01_01, 4'b01_10, 4'b01_11: sp = {1'b1, a[15:14]};
				4'b10_11, 4'b11_11: sp = 3'd3;
				4'b11_01: sp = 3'd7;
				default: sp = {1'b1, a[15:14]};  // 4,5,6 in layouts 2 and 3
			endcase
			return {8'd0, sp, a[13:0]};
		end
		case (a[15:14])
			2'b00: begin
				if (s_mode == zx_mem_pkg::MEM_PLUS3)
					rom = {2'b10, s_1ffd[2], s_rom};
				else if (s_mode == zx_mem_pkg::MEM_48K)
					rom = 4'b1111;
				else
					rom = {2'b01, 1'b1, s_rom};
				return {4'd0, `ZX_ROM_AREA, rom, a[13:0]};
			end
			2'b01:   return {8'd0, 3'd5, a[13:0]};
			2'b10:   return {8'd0, 3'd2, a[13:0]};
			default: return {5'd0, s_hi, s_bank, a[13:0]};
		endcase
	endfunction

	// ============================================================
	// Bus tasks
	// ============================================================

	task automatic wait_idle();
		do @(negedge clk_sys);
		while (exp_q.size() != 0 || sdram_out.req != sdram_ack);
	endtask

	task automatic apply_reset(input zx_mem_pkg::memory_mode_e mode);
		@(posedge clk_sys);
		reset    <= 1'b1;
		mem_mode <= mode;
		repeat (3) @(posedge clk_sys);
		reset  <= 1'b0;
		s_mode = mode;
		s_bank = 3'd0;
		s_rom  = 1'b0;
		s_lock = 1'b0;
		s_1ffd = 3'd0;
		s_eff7 = 1'b0;
		s_hi   = 3'd0;
		@(negedge clk_sys);
	endtask

	task automatic io_write(input logic [15:0] a, input logic [7:0] d);
		logic p1024;
		logic blocked;
		p1024   = (s_mode == zx_mem_pkg::MEM_P1024);
		blocked = (s_mode == zx_mem_pkg::MEM_48K) || (s_lock && (!p1024 || s_eff7));
		if (a == 16'h7FFD && !blocked) begin
			s_bank = d[2:0];
			s_rom  = d[4];
			s_lock = d[5];
			if (p1024 && !s_eff7)
				s_hi = {d[5], d[7:6]};
		end else if (a == 16'h1FFD && !blocked && s_mode == zx_mem_pkg::MEM_PLUS3) begin
			s_1ffd = d[2:0];
		end else if (a == 16'hEFF7 && p1024) begin
			s_eff7 = d[2];
		end
		@(posedge clk_sys);
		cpu <= '{addr: a, dout: d, mreq: 1'b0, iorq: 1'b1, rd: 1'b0, wr: 1'b1, m1: 1'b0};
		repeat (2) @(posedge clk_sys);
		cpu <= '0;
		repeat (2) @(negedge clk_sys);
	endtask

	// Memory cycle, strobe held 4 cycles; request only where the map allows
	task automatic mem_access(input logic [15:0] a, input logic [7:0] d, input logic wr);
		logic [24:0] ea;
		logic        ok;
		ea = exp_addr(a);
		ok = !wr || a[15:14] != 2'b00 || (s_mode == zx_mem_pkg::MEM_PLUS3 && s_1ffd[0]);
		@(posedge clk_sys);
		if (ok)
			exp_q.push_back('{addr: ea, we: wr, data: d});
		if (ok && wr)
			shadow_mem[int'(ea)] = d;
		cpu <= '{addr: a, dout: d, mreq: 1'b1, iorq: 1'b0, rd: ~wr, wr: wr, m1: 1'b0};
		repeat (4) @(posedge clk_sys);
		cpu <= '0;
		wait_idle();
		if (!wr && shadow_mem.exists(int'(ea))) begin
			assert (mem_rdata == shadow_mem[int'(ea)]) else begin
				$display("[ERROR] %0d ns: read %h at %h, expected %h",
					$time, mem_rdata, a, shadow_mem[int'(ea)]);
				errors++;
			end
		end
	endtask

	// Counts cycles to the next ce_cpu_p, noting where ce_cpu_n fell
	task automatic next_ce(output int n, output int n_mid);
		n     = 0;
		n_mid = 0;
		do begin
			@(negedge clk_sys);
			n++;
			if (ce_cpu_n)
				n_mid = n;
		end while (!ce_cpu_p && n < 200);
		if (!ce_cpu_p) begin
			$display("No ce_cpu_p pulse within 200 cycles at %0d ns", $time);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		test_count++;
		if (errors != test_err0)
			failed_tests++;
		$display("Test %0d %s: %s", test_count, name, (errors == test_err0) ? "pass" : "fail");
		test_err0 = errors;
	endtask

	// ============================================================
	// Stimulus
	// ============================================================

	initial begin
		int         n;
		int         n_mid;
		logic [7:0] pages [6];
		logic [7:0] d;
		seed_val     = $urandom(32'h532a_4a4a);
		reset        = 1'b1;
		cpu          = '0;
		dload        = '0;
		mem_mode     = zx_mem_pkg::MEM_128K;
		speed_sel    = 3'd0;
		pause        = 1'b0;
		pause_watch  = 1'b0;
		errors       = 0;
		failed_tests = 0;
		test_count   = 0;
		test_err0    = 0;
		cycles       = 0;
		pages        = '{8'd0, 8'd1, 8'd3, 8'd4, 8'd6, 8'd7};
		apply_reset(zx_mem_pkg::MEM_128K);

		for (int s = 0; s <= 4; s++) begin
			@(posedge clk_sys);
			speed_sel <= 3'(s);
			repeat (2) next_ce(n, n_mid);  // Skip the speed change
			repeat (3) begin
				next_ce(n, n_mid);
				assert (n == (32 >> s)) else begin
					$display("[ERROR] %0d ns: ce_cpu_p spacing %0d at speed %0d", $time, n, s);
					errors++;
				end
				// Negative phase sits half a CPU period after the positive one
				assert (n_mid == (16 >> s)) else begin
					$display("[ERROR] %0d ns: ce_cpu_n %0d cycles after ce_cpu_p at speed %0d",
						$time, n_mid, s);
					errors++;
				end
			end
		end
		@(posedge clk_sys);
		pause <= 1'b1;
		repeat (40) @(negedge clk_sys);
		pause_watch = 1'b1;
		repeat (64) @(negedge clk_sys);
		pause_watch = 1'b0;
		@(posedge clk_sys);
		pause     <= 1'b0;
		speed_sel <= 3'd0;
		end_test("CPU clock enables");

		foreach (pages[i]) begin
			io_write(16'h7FFD, pages[i]);
			d = $urandom_range(0, 255);
			mem_access(16'hC001 + 16'(pages[i]) * 16'h10, d, 1'b1);
		end
		foreach (pages[i]) begin
			io_write(16'h7FFD, pages[i]);
			mem_access(16'hC001 + 16'(pages[i]) * 16'h10, 8'h00, 1'b0);
		end
		mem_access(16'h4002, 8'h3C, 1'b1);
		mem_access(16'h4002, 8'h00, 1'b0);
		end_test("128K paging");

		io_write(16'h7FFD, 8'h21);
		io_write(16'h7FFD, 8'h06);  // Locked out
		mem_access(16'hC010, 8'h99, 1'b1);
		mem_access(16'hC010, 8'h00, 1'b0);
		mem_access(16'h0100, 8'h77, 1'b1);
		end_test("7FFD lock and ROM write");

		apply_reset(zx_mem_pkg::MEM_48K);
		mem_access(16'h0010, 8'h00, 1'b0);
		apply_reset(zx_mem_pkg::MEM_128K);
		mem_access(16'h0011, 8'h00, 1'b0);
		io_write(16'h7FFD, 8'h10);
		mem_access(16'h0012, 8'h00, 1'b0);
		apply_reset(zx_mem_pkg::MEM_PLUS3);
		io_write(16'h1FFD, 8'h04);
		io_write(16'h7FFD, 8'h10);
		mem_access(16'h0013, 8'h00, 1'b0);
		io_write(16'h1FFD, 8'h01);
		mem_access(16'h0123, 8'hA5, 1'b1);
		mem_access(16'h0123, 8'h00, 1'b0);
		io_write(16'h1FFD, 8'h07);
		mem_access(16'h4005, 8'h00, 1'b0);
		mem_access(16'hC006, 8'h00, 1'b0);
		end_test("ROM select and +3 special");

		@(posedge clk_sys);
		dload.active <= 1'b1;
		for (int i = 0; i < 4; i++) begin
			@(posedge clk_sys);
			d = $urandom_range(0, 255);
			exp_q.push_back('{addr: `ZX_ROM_BASE + 25'(i * 16'h1001 + 3), we: 1'b1, data: d});
			dload.addr <= 25'(i * 16'h1001 + 3);
			dload.data <= d;
			dload.wr   <= 1'b1;
			@(posedge clk_sys);
			dload.wr <= 1'b0;
			wait_idle();
		end
		@(posedge clk_sys);
		cpu <= '{addr: 16'hC020, dout: 8'h11, mreq: 1'b1, iorq: 1'b0, rd: 1'b0, wr: 1'b1, m1: 1'b0};
		repeat (4) @(posedge clk_sys);
		cpu <= '{addr: 16'hC020, dout: 8'h00, mreq: 1'b1, iorq: 1'b0, rd: 1'b1, wr: 1'b0, m1: 1'b0};
		repeat (4) @(posedge clk_sys);
		cpu <= '0;
		repeat (4) @(posedge clk_sys);
		dload.active <= 1'b0;
		repeat (4) @(negedge clk_sys);
		end_test("Boot ROM download");

		apply_reset(zx_mem_pkg::MEM_P1024);
		io_write(16'h7FFD, 8'hC3);
		mem_access(16'hC030, 8'h5E, 1'b1);
		io_write(16'h7FFD, 8'h84);
		mem_access(16'hC031, 8'h6F, 1'b1);
		io_write(16'hEFF7, 8'h04);
		io_write(16'h7FFD, 8'hE5);  // High bits ignored now
		mem_access(16'hC032, 8'h70, 1'b1);
		io_write(16'hEFF7, 8'h00);
		io_write(16'h7FFD, 8'hC3);
		mem_access(16'hC030, 8'h00, 1'b0);
		end_test("Pentagon 1024 pages");

		$display("Tests run %0d, failed %0d, errors %0d", test_count, failed_tests, errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- list.f
+incdir+verilog
verilog/zx_mem_pkg.sv
verilog/zx_cpu_clock.sv
verilog/zx_paging.sv
verilog/zx_addr_map.sv
verilog/zx_sdram_port.sv
verilog/zx_memory.sv
verif/zx_sdram_model.sv
verif/zx_memory_tb.sv

//--- Bender.yml
package:
  name: zx_memory

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/zx_mem_pkg.sv
      - verilog/zx_cpu_clock.sv
      - verilog/zx_paging.sv
      - verilog/zx_addr_map.sv
      - verilog/zx_sdram_port.sv
      - verilog/zx_memory.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - verif/zx_sdram_model.sv
      - verif/zx_memory_tb.sv
